// ==== all.f ====
+incdir+include
src/cpu_pkg.sv
src/bus_pkg.sv
src/fetch_unit.sv
src/decoder.sv
src/alu.sv
src/sequencer.sv
src/datapath.sv
src/bus_output.sv
src/core_6502.sv
test/core_6502_properties.sv
test/tb_core_6502.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_core_6502
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= run.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_core_6502.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module tb_core_6502;

    logic        clk_m1;
    logic        rst;
    logic [7:0]  data_i;
    logic [15:0] addr;
    logic [7:0]  dor;
    logic        rw;
    logic        sync;
    logic        jam;

    // flat 64 KiB memory
    logic [7:0]  mem [0:65535];
    logic [15:0] lfsr;
    logic [15:0] pc_gen;
    // reference copy of the registers
    logic [7:0]  m_a;
    logic [7:0]  m_x;
    logic [7:0]  m_y;
    logic        m_c;
    logic [7:0]  shadow [logic [15:0]];
    logic [15:0] exp_addr [$];
    logic [7:0]  exp_data [$];
    int          cycles;

    core_6502 dut (
        .clk_m1 (clk_m1),
        .rst    (rst),
        .data_i (data_i),
        .addr   (addr),
        .dor    (dor),
        .rw     (rw),
        .sync   (sync),
        .jam    (jam)
    );

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    task automatic value_error(input string name, input logic [15:0] expv,
                               input logic [15:0] gotv);
        $display("Error at %0t: %s expected %h, got %h", $time, name, expv, gotv);
        $display("Regression failed");
        $fatal(1, "value mismatch");
    endtask

    // galois lfsr, one step per bit
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [15:0] v);
        v = 16'h0000;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic put(input logic [7:0] b);
        mem[pc_gen] = b;
        pc_gen      = pc_gen + 16'd1;
    endtask

    task automatic load_imm(input logic [7:0] opc, output logic [7:0] val);
        logic [15:0] v;
        draw_bits(8, v);
        put(opc);
        put(v[7:0]);
        val = v[7:0];
    endtask

    // adc 69, sbc e9 is add of the inverted operand
    task automatic add_imm(input logic [7:0] opc);
        logic [15:0] v;
        logic [7:0]  operand;
        logic [8:0]  sum;
        draw_bits(8, v);
        put(opc);
        put(v[7:0]);
        operand = (opc == 8'hE9) ? ~v[7:0] : v[7:0];
        sum     = {1'b0, m_a} + {1'b0, operand} + {8'd0, m_c};
        m_a     = sum[7:0];
        m_c     = sum[8];
    endtask

    // zero-page opcode given, absolute form has bit 3 set
    task automatic store_reg(input logic [7:0] opc, input logic [7:0] val,
                             input logic is_abs, output logic [15:0] tgt);
        logic [15:0] v;
        if (is_abs) begin
            draw_bits(12, v);
            tgt = 16'h2000 | v;
            put(opc | 8'h08);
            put(tgt[7:0]);
            put(tgt[15:8]);
        end else begin
            draw_bits(8, v);
            tgt = {8'h00, v[7:0]};
            put(opc);
            put(tgt[7:0]);
        end
        exp_addr.push_back(tgt);
        exp_data.push_back(val);
        shadow[tgt] = val;
    endtask

    task automatic load_mem(input logic [7:0] opc, input logic [15:0] tgt,
                            input logic is_abs, output logic [7:0] val);
        put(is_abs ? (opc | 8'h08) : opc);
        put(tgt[7:0]);
        if (is_abs) begin
            put(tgt[15:8]);
        end
        val = shadow[tgt];
    endtask

    task automatic build_program;
        logic [15:0] t_zp;
        logic [15:0] t_abs;
        logic [15:0] t;
        pc_gen = `CPU_RESET_PC;
        for (int r = 0; r < 4; r++) begin
            load_imm(8'hA9, m_a);
            load_imm(8'hA2, m_x);
            load_imm(8'hA0, m_y);
            store_reg(8'h85, m_a, 1'b0, t_zp);
            store_reg(8'h86, m_x, 1'b1, t_abs);
            store_reg(8'h84, m_y, 1'b0, t);
            // clc, adc, then sec, sbc, adc on the carry chain
            put(8'h18);
            m_c = 1'b0;
            add_imm(8'h69);
            store_reg(8'h85, m_a, 1'b1, t);
            put(8'h38);
            m_c = 1'b1;
            add_imm(8'hE9);
            store_reg(8'h85, m_a, 1'b0, t);
            add_imm(8'h69);
            store_reg(8'h85, m_a, 1'b1, t);
            // logic ops on a
            load_imm(8'h29, t[7:0]);
            m_a = m_a & t[7:0];
            load_imm(8'h09, t[7:0]);
            m_a = m_a | t[7:0];
            load_imm(8'h49, t[7:0]);
            m_a = m_a ^ t[7:0];
            store_reg(8'h85, m_a, 1'b0, t);
            // tax inx stx, tay dey sty
            put(8'hAA);
            put(8'hE8);
            m_x = m_a + 8'd1;
            store_reg(8'h86, m_x, 1'b0, t);
            put(8'hA8);
            put(8'h88);
            m_y = m_a - 8'd1;
            store_reg(8'h84, m_y, 1'b1, t);
            // dex txa sta, iny tya sta, clv
            put(8'hCA);
            put(8'h8A);
            m_x = m_x - 8'd1;
            m_a = m_x;
            store_reg(8'h85, m_a, 1'b0, t);
            put(8'hC8);
            put(8'h98);
            m_y = m_y + 8'd1;
            m_a = m_y;
            store_reg(8'h85, m_a, 1'b1, t);
            put(8'hB8);
            // read back earlier stores
            load_mem(8'hA5, t_zp, 1'b0, m_a);
            store_reg(8'h85, m_a, 1'b1, t);
            load_mem(8'hA6, t_abs, 1'b1, m_x);
            store_reg(8'h86, m_x, 1'b0, t);
            load_mem(8'hA4, t_zp, 1'b0, m_y);
            store_reg(8'h84, m_y, 1'b1, t);
        end
        // jmp is outside the core's set and jams it
        put(8'h4C);
        put(8'h00);
        put(8'h04);
    endtask

    initial begin
        clk_m1 = 1'b0;
        forever #20 clk_m1 = ~clk_m1;
    end

    // read data follows addr, driven on the falling edge
    always @(negedge clk_m1) begin
        data_i <= mem[addr];
    end

    // write path, checked against the expected list in order
    always @(posedge clk_m1) begin
        if (!rst && rw === 1'b0) begin
            mem[addr] <= dor;
            if (exp_addr.size() == 0) begin
                stop_run("write seen after the expected writes ran out");
            end else begin
                assert (addr === exp_addr[0])
                    else value_error("addr", exp_addr[0], addr);
                assert (dor === exp_data[0])
                    else value_error("dor", {8'h00, exp_data[0]}, {8'h00, dor});
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    initial begin
        rst    = 1'b1;
        data_i = 8'h00;
        lfsr   = 16'd43720;
        m_a    = 8'h00;
        m_x    = 8'h00;
        m_y    = 8'h00;
        m_c    = 1'b0;
        // fill depends on both address bytes
        for (int i = 0; i < 65536; i++) begin
            mem[i] = i[15:8] ^ i[7:0] ^ 8'h5A;
        end
        build_program();

        repeat (16) begin
            @(posedge clk_m1);
            @(negedge clk_m1);
            assert (rw === 1'b1)
                else stop_run("write strobe active during reset");
        end
        rst = 1'b0;

        // first fetch from the reset address
        cycles = 0;
        while (sync !== 1'b1 && cycles < 8) begin
            @(negedge clk_m1);
            cycles++;
        end
        assert (sync === 1'b1)
            else stop_run("no opcode fetch after reset");
        assert (addr === `CPU_RESET_PC)
            else value_error("addr", `CPU_RESET_PC, addr);

        // run until the jmp jams the core
        cycles = 0;
        while (jam !== 1'b1 && cycles < 5000) begin
            @(negedge clk_m1);
            cycles++;
        end
        assert (jam === 1'b1)
            else stop_run("core never reached the jam state");
        repeat (8) @(negedge clk_m1);
        assert (jam === 1'b1)
            else stop_run("jam dropped before reset");
        assert (exp_addr.size() == 0)
            else stop_run("program ended with expected writes missing");
        // bound bus protocol checks
        if (dut.u_properties.fail_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            stop_run("bus protocol assertion failed during the run");
        end
    end

endmodule

`default_nettype wire

// ==== test/core_6502_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_6502_properties (
    input logic clk_m1,
    input logic rst,
    input logic rw,
    input logic sync,
    input logic jam
);

    // number of failed assertions
    int fail_count = 0;

    // jam only clears through reset
    property jam_holds;
        @(posedge clk_m1) disable iff (rst) jam |=> jam;
    endproperty

    // a jammed core drives no writes
    property no_write_in_jam;
        @(posedge clk_m1) disable iff (rst) jam |-> rw;
    endproperty

    // opcode fetch is always a read
    property read_on_fetch;
        @(posedge clk_m1) disable iff (rst) sync |-> rw;
    endproperty

    // every instruction is at least two cycles
    property sync_single_pulse;
        @(posedge clk_m1) disable iff (rst) sync |=> !sync;
    endproperty

    assert property (jam_holds)
        else begin
            $error("jam dropped without reset");
            fail_count++;
        end
    assert property (no_write_in_jam)
        else begin
            $error("rw low while jammed");
            fail_count++;
        end
    assert property (read_on_fetch)
        else begin
            $error("rw low in a sync cycle");
            fail_count++;
        end
    assert property (sync_single_pulse)
        else begin
            $error("sync high in two consecutive cycles");
            fail_count++;
        end

endmodule

// attach to every core instance
bind core_6502 core_6502_properties u_properties (
    .clk_m1 (clk_m1),
    .rst    (rst),
    .rw     (rw),
    .sync   (sync),
    .jam    (jam)
);

`default_nettype wire

// ==== src/core_6502.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_6502 (
    input  logic        clk_m1,
    input  logic        rst,
    input  logic [7:0]  data_i,
    output logic [15:0] addr,
    output logic [7:0]  dor,
    output logic        rw,
    output logic        sync,
    output logic        jam
);
    import cpu_pkg::*;
    import bus_pkg::*;

    logic [7:0] data;
    opcode_t    ir;
    logic       two_cycle;
    dec_ctl_t   ctl;
    bus_ctl_t   bus_ctl;
    logic       exec;
    logic [7:0] result;

    // input side
    fetch_unit u_fetch (
        .clk_m1    (clk_m1),
        .rst       (rst),
        .data_i    (data_i),
        .sync      (sync),
        .data      (data),
        .ir        (ir),
        .two_cycle (two_cycle)
    );

    decoder u_decoder (
        .ir  (ir),
        .ctl (ctl)
    );

    sequencer u_sequencer (
        .clk_m1    (clk_m1),
        .rst       (rst),
        .two_cycle (two_cycle),
        .ctl       (ctl),
        .sync      (sync),
        .exec      (exec),
        .bus_ctl   (bus_ctl),
        .jam       (jam)
    );

    // registers, flags and alu
    datapath u_datapath (
        .clk_m1 (clk_m1),
        .rst    (rst),
        .exec   (exec),
        .ctl    (ctl),
        .data   (data),
        .result (result)
    );

    // output side
    bus_output u_bus_output (
        .clk_m1  (clk_m1),
        .rst     (rst),
        .bus_ctl (bus_ctl),
        .data_i  (data_i),
        .data    (data),
        .exec    (exec),
        .mem_wr  (ctl.mem_wr),
        .result  (result),
        .addr    (addr),
        .dor     (dor),
        .rw      (rw)
    );

endmodule

`default_nettype wire

// ==== src/bus_output.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module bus_output (
    input  logic              clk_m1,
    input  logic              rst,
    input  bus_pkg::bus_ctl_t bus_ctl,
    input  logic [7:0]        data_i,
    input  logic [7:0]        data,
    input  logic              exec,
    input  logic              mem_wr,
    input  logic [7:0]        result,
    output logic [15:0]       addr,
    output logic [7:0]        dor,
    output logic              rw
);
    import bus_pkg::*;

    logic [15:0] pc;
    logic [15:0] pc_next;
    logic [7:0]  adl;
    logic [7:0]  adh;
    logic        wr;

    // pc and addr match whenever addr comes from the pc
    assign pc_next = bus_ctl.inc_pc ? pc + 16'd1 : pc;

    // one address byte from its source
    function automatic logic [7:0] pick(input addr_src_e src, input logic [7:0] pc_byte,
                                        input logic [7:0] hold_byte);
        case (src)
            ADDR_DATA_IN:  pick = data_i;
            ADDR_DATA_REG: pick = data;
            ADDR_ZERO:     pick = 8'h00;
            ADDR_HOLD:     pick = hold_byte;
            default:       pick = pc_byte;
        endcase
    endfunction

    always_comb begin
        adl = pick(bus_ctl.adl_src, pc_next[7:0], addr[7:0]);
        adh = pick(bus_ctl.adh_src, pc_next[15:8], addr[15:8]);
    end

    always_ff @(posedge clk_m1) begin
        if (rst) begin
            pc   <= `CPU_RESET_PC;
            addr <= 16'h0000;
        end else begin
            pc <= pc_next;
            if (bus_ctl.update_addr) begin
                addr <= {adh, adl};
            end
        end
    end

    // write strobe and data follow the store cycle directly
    assign wr  = exec & mem_wr;
    assign rw  = !wr;
    assign dor = wr ? result : data;

endmodule

`default_nettype wire

// ==== src/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module datapath (
    input  logic              clk_m1,
    input  logic              rst,
    input  logic              exec,
    input  cpu_pkg::dec_ctl_t ctl,
    input  logic [7:0]        data,
    output logic [7:0]        result
);
    import cpu_pkg::*;

    logic [7:0] a;
    logic [7:0] x;
    logic [7:0] y;
    logic [7:0] p;
    logic [7:0] p_next;
    logic [7:0] sb;
    logic [7:0] db;
    logic [7:0] alu_out;
    logic       alu_c;
    logic       alu_v;
    logic       alu_ci;
    logic       use_alu;

    // sb carries registers, db carries data and p
    always_comb begin
        case (ctl.a_src)
            REG_A:    sb = a;
            REG_X:    sb = x;
            REG_Y:    sb = y;
            REG_ONES: sb = 8'hFF;
            default:  sb = 8'h00;
        endcase
        case (ctl.b_src)
            REG_DATA:  db = data;
            REG_NDATA: db = ~data;
            REG_P:     db = p;
            REG_ONES:  db = 8'hFF;
            default:   db = 8'h00;
        endcase
    end

    assign alu_ci = ctl.alu_cin_one | (ctl.alu_cin_from_c & p[`CPU_FLAG_C]);

    alu u_alu (
        .op  (ctl.alu_op),
        .ai  (sb),
        .bi  (db),
        .ci  (alu_ci),
        .out (alu_out),
        .c   (alu_c),
        .v   (alu_v)
    );

    // loads pass db through the alu, transfers and stores take sb
    assign use_alu = (ctl.alu_op != ALU_PASS) || (ctl.a_src == REG_ZERO);
    assign result  = use_alu ? alu_out : sb;

    always_comb begin
        p_next = (p | ctl.set_mask) & ~ctl.clear_mask;
        if (ctl.up_c) begin
            p_next[`CPU_FLAG_C] = alu_c;
        end
        if (ctl.up_v) begin
            p_next[`CPU_FLAG_V] = alu_v;
        end
        if (ctl.up_nz) begin
            p_next[`CPU_FLAG_Z] = (result == 8'h00);
            p_next[`CPU_FLAG_N] = result[7];
        end
        // bits 4 and 5 do not exist, read as 0 and 1
        p_next[4] = 1'b0;
        p_next[5] = 1'b1;
    end

    always_ff @(posedge clk_m1) begin
        if (rst) begin
            a <= 8'h00;
            x <= 8'h00;
            y <= 8'h00;
            p <= `CPU_INITIAL_STATUS;
        end else if (exec) begin
            case (ctl.dst)
                REG_A:   a <= result;
                REG_X:   x <= result;
                REG_Y:   y <= result;
                default: ;
            endcase
            p <= p_next;
        end
    end

endmodule

`default_nettype wire

// ==== src/sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sequencer (
    input  logic              clk_m1,
    input  logic              rst,
    input  logic              two_cycle,
    input  cpu_pkg::dec_ctl_t ctl,
    output logic              sync,
    output logic              exec,
    output bus_pkg::bus_ctl_t bus_ctl,
    output logic              jam
);
    import cpu_pkg::*;
    import bus_pkg::*;

    typedef enum logic [2:0] {
        ST_T1   = 3'd0,
        ST_T0T2 = 3'd1,
        ST_T2   = 3'd2,
        ST_T3   = 3'd3,
        ST_T0   = 3'd4,
        ST_JAM  = 3'd7
    } state_e;

    state_e state;
    state_e state_next;
    logic   mem_op;

    // zp and abs forms must move data one way or the other
    assign mem_op = ctl.mem_rd | ctl.mem_wr;

    // reset lands in t0t2 with a nop in ir
    // so the pc reaches addr before the first sync
    always_ff @(posedge clk_m1) begin
        if (rst) begin
            state <= ST_T0T2;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        bus_ctl.adl_src     = ADDR_PC;
        bus_ctl.adh_src     = ADDR_PC;
        bus_ctl.inc_pc      = 1'b0;
        bus_ctl.update_addr = 1'b1;
        sync                = 1'b0;
        exec                = 1'b0;
        state_next          = state;
        case (state)
            ST_T1: begin
                // fetch, and finish the previous op unless it was a store
                sync           = 1'b1;
                exec           = !ctl.mem_wr;
                bus_ctl.inc_pc = 1'b1;
                state_next     = two_cycle ? ST_T0T2 : ST_T2;
            end
            ST_T0T2: begin
                // operand byte read, skip it only for two-byte ops
                bus_ctl.inc_pc = !ctl.single_byte;
                state_next     = (ctl.op_class == OP_IMPL) ? ST_T1 : ST_JAM;
            end
            ST_T2: begin
                state_next = ST_JAM;
                if (mem_op && ctl.op_class == OP_ZPG) begin
                    bus_ctl.adl_src = ADDR_DATA_IN;
                    bus_ctl.adh_src = ADDR_ZERO;
                    state_next      = ST_T0;
                end else if (mem_op && ctl.op_class == OP_ABS) begin
                    // go on to the high address byte
                    bus_ctl.inc_pc = 1'b1;
                    state_next     = ST_T3;
                end
            end
            ST_T3: begin
                // low byte held in data, high byte on the bus
                bus_ctl.adl_src = ADDR_DATA_REG;
                bus_ctl.adh_src = ADDR_DATA_IN;
                state_next      = ST_T0;
            end
            ST_T0: begin
                // operand cycle, stores write here
                exec           = ctl.mem_wr;
                bus_ctl.inc_pc = 1'b1;
                state_next     = ST_T1;
            end
            default: begin
                // jammed, bus frozen until reset
                bus_ctl.adl_src     = ADDR_HOLD;
                bus_ctl.adh_src     = ADDR_HOLD;
                bus_ctl.update_addr = 1'b0;
                state_next          = ST_JAM;
            end
        endcase
    end

    assign jam = (state == ST_JAM);

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  cpu_pkg::alu_op_e op,
    input  logic [7:0]       ai,
    input  logic [7:0]       bi,
    input  logic             ci,
    output logic [7:0]       out,
    output logic             c,
    output logic             v
);
    import cpu_pkg::*;

    logic [8:0] sum;

    // binary add only, no decimal mode
    assign sum = {1'b0, ai} + {1'b0, bi} + {8'd0, ci};

    always_comb begin
        c = 1'b0;
        v = 1'b0;
        case (op)
            ALU_OR:  out = ai | bi;
            ALU_AND: out = ai & bi;
            ALU_EOR: out = ai ^ bi;
            ALU_ADD: begin
                out = sum[7:0];
                c   = sum[8];
                // same-sign operands giving the other sign
                v   = (ai[7] == bi[7]) && (sum[7] != ai[7]);
            end
            // pass hands db straight through
            default: out = bi;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module decoder (
    input  cpu_pkg::opcode_t ir,
    output cpu_pkg::dec_ctl_t ctl
);
    import cpu_pkg::*;

    opcode_fields_t f;
    logic           is_mem;
    op_class_e      mem_class;
    reg_sel_e       idx;

    assign f = ir.fields;
    // zero page is bbb 001, absolute is bbb 011
    assign is_mem    = (f.bbb == 3'b001) || (f.bbb == 3'b011);
    assign mem_class = f.bbb[1] ? OP_ABS : OP_ZPG;
    // group 10 works on x, group 00 on y
    assign idx       = f.cc[1] ? REG_X : REG_Y;

    always_comb begin
        ctl          = '0;
        ctl.op_class = OP_NONE;
        ctl.dst      = REG_ZERO;
        ctl.a_src    = REG_ZERO;
        ctl.b_src    = REG_DATA;
        ctl.alu_op   = ALU_PASS;
        case (f.cc)
            2'b01: begin
                // alu group, immediate is bbb 010
                if (f.bbb == 3'b010 || is_mem) begin
                    ctl.op_class = is_mem ? mem_class : OP_IMPL;
                    ctl.mem_rd   = is_mem;
                    ctl.a_src    = REG_A;
                    ctl.dst      = REG_A;
                    ctl.up_nz    = 1'b1;
                end
                case (f.aaa)
                    3'b000: ctl.alu_op = ALU_OR;
                    3'b001: ctl.alu_op = ALU_AND;
                    3'b010: ctl.alu_op = ALU_EOR;
                    3'b011: begin
                        ctl.alu_op         = ALU_ADD;
                        ctl.alu_cin_from_c = 1'b1;
                        ctl.up_c           = 1'b1;
                        ctl.up_v           = 1'b1;
                    end
                    3'b100: begin
                        // sta, no immediate form
                        ctl.op_class = is_mem ? mem_class : OP_NONE;
                        ctl.mem_rd   = 1'b0;
                        ctl.mem_wr   = 1'b1;
                        ctl.dst      = REG_ZERO;
                        ctl.up_nz    = 1'b0;
                    end
                    3'b101: ctl.a_src = REG_ZERO;
                    3'b110: begin
                        // cmp, a - m with the result dropped
                        ctl.alu_op      = ALU_ADD;
                        ctl.b_src       = REG_NDATA;
                        ctl.alu_cin_one = 1'b1;
                        ctl.dst         = REG_ZERO;
                        ctl.up_c        = 1'b1;
                    end
                    default: begin
                        // sbc
                        ctl.alu_op         = ALU_ADD;
                        ctl.b_src          = REG_NDATA;
                        ctl.alu_cin_from_c = 1'b1;
                        ctl.up_c           = 1'b1;
                        ctl.up_v           = 1'b1;
                    end
                endcase
            end
            2'b00, 2'b10: begin
                if (f.aaa == 3'b101 && (f.bbb == 3'b000 || is_mem)) begin
                    // ldx, ldy
                    ctl.op_class = is_mem ? mem_class : OP_IMPL;
                    ctl.mem_rd   = is_mem;
                    ctl.dst      = idx;
                    ctl.up_nz    = 1'b1;
                end else if (f.aaa == 3'b100 && is_mem) begin
                    // stx, sty
                    ctl.op_class = mem_class;
                    ctl.a_src    = idx;
                    ctl.mem_wr   = 1'b1;
                end else if (f.bbb == 3'b010) begin
                    // implied column, all single byte
                    ctl.single_byte = 1'b1;
                    ctl.up_nz       = 1'b1;
                    ctl.op_class    = OP_IMPL;
                    case ({f.cc[1], f.aaa})
                        // txa, tax, dex, nop
                        4'b1100: {ctl.a_src, ctl.dst} = {REG_X, REG_A};
                        4'b1101: {ctl.a_src, ctl.dst} = {REG_A, REG_X};
                        4'b1110: begin
                            {ctl.a_src, ctl.dst, ctl.b_src} = {REG_X, REG_X, REG_ONES};
                            ctl.alu_op = ALU_ADD;
                        end
                        4'b1111: ctl.up_nz = 1'b0;
                        // dey, tay, iny, inx
                        4'b0100: begin
                            {ctl.a_src, ctl.dst, ctl.b_src} = {REG_Y, REG_Y, REG_ONES};
                            ctl.alu_op = ALU_ADD;
                        end
                        4'b0101: {ctl.a_src, ctl.dst} = {REG_A, REG_Y};
                        4'b0110, 4'b0111: begin
                            ctl.a_src       = f.aaa[0] ? REG_X : REG_Y;
                            ctl.dst         = ctl.a_src;
                            ctl.b_src       = REG_ZERO;
                            ctl.alu_op      = ALU_ADD;
                            ctl.alu_cin_one = 1'b1;
                        end
                        // shifts and the rest stay out
                        default: ctl.op_class = OP_NONE;
                    endcase
                end else if (f.bbb == 3'b110 && !f.cc[1]) begin
                    ctl.single_byte = 1'b1;
                    ctl.op_class    = OP_IMPL;
                    case (f.aaa)
                        3'b000: ctl.clear_mask = 8'h01 << `CPU_FLAG_C;
                        3'b001: ctl.set_mask   = 8'h01 << `CPU_FLAG_C;
                        3'b101: ctl.clear_mask = 8'h01 << `CPU_FLAG_V;
                        3'b100: begin
                            // tya
                            {ctl.a_src, ctl.dst} = {REG_Y, REG_A};
                            ctl.up_nz = 1'b1;
                        end
                        default: ctl.op_class = OP_NONE;
                    endcase
                end
            end
            // group 11 has no legal opcodes
            default: ctl.op_class = OP_NONE;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic             clk_m1,
    input  logic             rst,
    input  logic [7:0]       data_i,
    input  logic             sync,
    output logic [7:0]       data,
    output cpu_pkg::opcode_t ir,
    output logic             two_cycle
);
    import cpu_pkg::*;

    opcode_t op_in;

    assign op_in.raw = data_i;

    // input byte, one cycle behind the bus
    always_ff @(posedge clk_m1) begin
        data <= data_i;
    end

    // opcode latched at the end of the sync cycle
    always_ff @(posedge clk_m1) begin
        if (rst) begin
            ir.raw <= OPC_NOP;
        end else if (sync) begin
            ir <= op_in;
        end
    end

    // predecode straight off the bus during sync
    // ld and cp immediate, then the imm/implied column, then the implied column
    assign two_cycle = (op_in.raw ==? 8'b1??0_00?0) ||
                       (op_in.raw ==? 8'b???0_10??) ||
                       (op_in.raw ==? 8'b???1_10?0);

endmodule

`default_nettype wire

// ==== src/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // source of one address byte
    typedef enum logic [2:0] {
        ADDR_PC       = 3'd0,
        ADDR_DATA_IN  = 3'd1,
        ADDR_DATA_REG = 3'd2,
        ADDR_ZERO     = 3'd3,
        ADDR_HOLD     = 3'd4
    } addr_src_e;

    // per-cycle control of the address side
    typedef struct packed {
        addr_src_e adl_src;
        addr_src_e adh_src;
        logic      inc_pc;
        logic      update_addr;
    } bus_ctl_t;

endpackage

`default_nettype wire

// ==== src/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // opcode layout is aaa_bbb_cc
    // aaa picks the operation, bbb the addressing mode, cc the group
    typedef struct packed {
        logic [2:0] aaa;
        logic [2:0] bbb;
        logic [1:0] cc;
    } opcode_fields_t;

    // raw byte for predecode, fields for the main decoder
    typedef union packed {
        logic [7:0]     raw;
        opcode_fields_t fields;
    } opcode_t;

    // implied nop, held in ir out of reset
    localparam logic [7:0] OPC_NOP = 8'hEA;

    // timing class of an instruction
    typedef enum logic [2:0] {
        OP_IMPL = 3'd0,
        OP_ZPG  = 3'd1,
        OP_ABS  = 3'd2,
        OP_NONE = 3'd7
    } op_class_e;

    // subtract is add with db inverted
    typedef enum logic [2:0] {
        ALU_OR   = 3'd0,
        ALU_AND  = 3'd1,
        ALU_EOR  = 3'd2,
        ALU_ADD  = 3'd3,
        ALU_PASS = 3'd4
    } alu_op_e;

    // register and bus selects
    typedef enum logic [2:0] {
        REG_A     = 3'd0,
        REG_X     = 3'd1,
        REG_Y     = 3'd2,
        REG_P     = 3'd3,
        REG_DATA  = 3'd4,
        REG_NDATA = 3'd5,
        REG_ZERO  = 3'd6,
        REG_ONES  = 3'd7
    } reg_sel_e;

    typedef struct packed {
        op_class_e  op_class;
        reg_sel_e   dst;
        reg_sel_e   a_src;
        reg_sel_e   b_src;
        alu_op_e    alu_op;
        logic       alu_cin_from_c;
        logic       alu_cin_one;
        logic       up_nz;
        logic       up_c;
        logic       up_v;
        logic       mem_rd;
        logic       mem_wr;
        logic       single_byte;
        logic [7:0] set_mask;
        logic [7:0] clear_mask;
    } dec_ctl_t;

endpackage

`default_nettype wire

// ==== include/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// first opcode fetched after reset
`define CPU_RESET_PC 16'h0400

// flag bit positions in p
`define CPU_FLAG_C 0
`define CPU_FLAG_Z 1
`define CPU_FLAG_V 6
`define CPU_FLAG_N 7

// p after reset
// bit 5 always reads one, irq disable set
`define CPU_INITIAL_STATUS 8'h24

`endif
